/* src/mdu_pkg.sv */
// ----------------------------------------------------------------------
// MDU shared definitions
// Word width, RV32M operation codes, request/response structs,
// unit control structs and the state encodings of both units
// ----------------------------------------------------------------------
package mdu_pkg;

    parameter int XLEN = 32;                  // Fixed by RV32

    typedef logic [XLEN-1:0] md_word_t;

    // Operation codes follow the RV32M funct3 field
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } md_op_e;

    typedef struct packed {
        md_op_e   op;
        md_word_t src1;                       // rs1 value
        md_word_t src2;                       // rs2 value
    } md_req_t;

    typedef struct packed {
        md_word_t rslt;
    } md_resp_t;

    // ------------------------------------------------------------------
    // Unit controls and states
    // ------------------------------------------------------------------
    typedef struct packed {
        logic src1_signed;
        logic src2_signed;
        logic high;                           // Return upper product word
    } mul_ctrl_t;

    typedef struct packed {
        logic signed_op;
        logic rem;                            // Return remainder
    } div_ctrl_t;

    typedef enum logic [1:0] {MUL_IDLE, MUL_EXEC, MUL_RET} mul_state_e;

    typedef enum logic [1:0] {DIV_IDLE, DIV_CHECK, DIV_EXEC, DIV_RET} div_state_e;

endpackage

/* src/mdu_dispatch.sv */
// ----------------------------------------------------------------------
// MDU dispatcher
// Decodes a request into a multiplier or divider start with its
// controls, tracks busy and merges the two unit completions
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module mdu_dispatch (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  mdu_pkg::md_req_t  req_i,
    output logic              mul_start_o,
    output mdu_pkg::mul_ctrl_t mul_ctrl_o,
    output logic              div_start_o,
    output mdu_pkg::div_ctrl_t div_ctrl_o,
    output mdu_pkg::md_word_t src1_o,
    output mdu_pkg::md_word_t src2_o,
    input  logic              mul_done_i,
    input  mdu_pkg::md_resp_t mul_resp_i,
    input  logic              div_done_i,
    input  mdu_pkg::md_resp_t div_resp_i,
    output logic              busy_o,
    output logic              done_o,
    output mdu_pkg::md_resp_t resp_o
);
    import mdu_pkg::*;

    logic      accept;
    logic      mul_sel;
    logic      div_sel;
    mul_ctrl_t mul_ctrl_d;
    div_ctrl_t div_ctrl_d;
    logic      busy_q;

    assign accept = start_i & ~busy_q;        // Starts while busy are dropped

    // ------------------------------------------------------------------
    // Operation decode
    // ------------------------------------------------------------------
    always_comb begin
        mul_sel    = 1'b0;
        div_sel    = 1'b0;
        mul_ctrl_d = '0;
        div_ctrl_d = '0;
        case (req_i.op)
            MUL:    mul_sel = 1'b1;           // Low word, sign irrelevant
            MULH: begin
                mul_sel                = 1'b1;
                mul_ctrl_d.src1_signed = 1'b1;
                mul_ctrl_d.src2_signed = 1'b1;
                mul_ctrl_d.high        = 1'b1;
            end
            MULHSU: begin
                mul_sel                = 1'b1;
                mul_ctrl_d.src1_signed = 1'b1;
                mul_ctrl_d.high        = 1'b1;
            end
            MULHU: begin
                mul_sel         = 1'b1;
                mul_ctrl_d.high = 1'b1;
            end
            DIV: begin
                div_sel              = 1'b1;
                div_ctrl_d.signed_op = 1'b1;
            end
            DIVU:   div_sel = 1'b1;
            REM: begin
                div_sel              = 1'b1;
                div_ctrl_d.signed_op = 1'b1;
                div_ctrl_d.rem       = 1'b1;
            end
            default: begin                    // REMU
                div_sel        = 1'b1;
                div_ctrl_d.rem = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q      <= 1'b0;
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
        end else begin
            mul_start_o <= accept & mul_sel;  // One-cycle unit strobes
            div_start_o <= accept & div_sel;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            mul_ctrl_o <= mul_ctrl_d;
            div_ctrl_o <= div_ctrl_d;
            src1_o     <= req_i.src1;
            src2_o     <= req_i.src2;
        end
    end

    assign busy_o = busy_q;
    assign done_o = mul_done_i | div_done_i;
    assign resp_o = mul_done_i ? mul_resp_i : div_resp_i;

    a_no_start_busy : assert property (@(posedge clk_i) disable iff (rst_i)
        !(start_i && busy_o));
    a_done_exclusive : assert property (@(posedge clk_i) disable iff (rst_i)
        !(mul_done_i && div_done_i));
    a_done_in_busy : assert property (@(posedge clk_i) disable iff (rst_i)
        done_o |-> busy_o);

endmodule

/* src/mdu_multiplier.sv */
// ----------------------------------------------------------------------
// MDU multiplier
// Registers sign- or zero-extended operands, forms the full signed
// product in one step and returns the high or low word
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module mdu_multiplier (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               start_i,
    input  mdu_pkg::mul_ctrl_t ctrl_i,
    input  mdu_pkg::md_word_t  src1_i,
    input  mdu_pkg::md_word_t  src2_i,
    output logic               done_o,
    output mdu_pkg::md_resp_t  resp_o
);
    import mdu_pkg::*;

    mul_state_e               state_q;
    logic signed [XLEN:0]     src1_q;         // 33-bit extended operands
    logic signed [XLEN:0]     src2_q;
    logic                     high_q;
    logic signed [2*XLEN+1:0] product_q;

    // ------------------------------------------------------------------
    // State sequence
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= MUL_IDLE;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (start_i) begin
                        state_q <= MUL_EXEC;
                    end
                end
                MUL_EXEC: state_q <= MUL_RET;
                default:  state_q <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == MUL_IDLE) begin
            src1_q <= {ctrl_i.src1_signed & src1_i[XLEN-1], src1_i};
            src2_q <= {ctrl_i.src2_signed & src2_i[XLEN-1], src2_i};
            high_q <= ctrl_i.high;
        end
        if (state_q == MUL_EXEC) begin
            product_q <= src1_q * src2_q;
        end
    end

    assign done_o = (state_q == MUL_RET);

    always_comb begin
        if (state_q != MUL_RET) begin
            resp_o.rslt = '0;
        end else if (high_q) begin
            resp_o.rslt = product_q[2*XLEN-1:XLEN];
        end else begin
            resp_o.rslt = product_q[XLEN-1:0];
        end
    end

    a_done_after_exec : assert property (@(posedge clk_i) disable iff (rst_i)
        done_o |-> $past(state_q) == MUL_EXEC);

endmodule

/* src/mdu_divider.sv */
// ----------------------------------------------------------------------
// MDU divider
// Radix-2 restoring divider. A check step handles division by zero
// and takes operand magnitudes, 32 shift-subtract steps follow and
// the return step applies the sign fix-up
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module mdu_divider (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               start_i,
    input  mdu_pkg::div_ctrl_t ctrl_i,
    input  mdu_pkg::md_word_t  src1_i,
    input  mdu_pkg::md_word_t  src2_i,
    output logic               done_o,
    output mdu_pkg::md_resp_t  resp_o
);
    import mdu_pkg::*;

    localparam int CNT_W = $clog2(XLEN);

    div_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;                  // Remaining iterations
    md_word_t         rem_q;                  // Dividend until the check
    md_word_t         quo_q;
    md_word_t         divisor_q;
    logic             dividend_neg_q;
    logic             divisor_neg_q;
    logic             quo_neg_q;              // Result fix-up flags
    logic             rem_neg_q;
    logic             is_rem_q;

    logic             divisor_zero;
    md_word_t         dividend_mag;
    md_word_t         divisor_mag;
    logic [XLEN:0]    shifted;
    logic [XLEN+1:0]  diff;
    logic             q_bit;

    assign divisor_zero = (divisor_q == '0);
    assign dividend_mag = dividend_neg_q ? -rem_q : rem_q;
    assign divisor_mag  = divisor_neg_q ? -divisor_q : divisor_q;

    // One restoring step
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_q};
    assign q_bit   = ~diff[XLEN+1];           // No borrow, subtract fits

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_CHECK;
                    end
                end
                DIV_CHECK: begin
                    state_q <= divisor_zero ? DIV_RET : DIV_EXEC;
                    cnt_q   <= CNT_W'(XLEN - 1);
                end
                DIV_EXEC: begin
                    if (cnt_q == '0) begin
                        state_q <= DIV_RET;
                    end
                    cnt_q <= cnt_q - 1'b1;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        case (state_q)
            DIV_IDLE: begin
                if (start_i) begin
                    rem_q          <= src1_i;
                    divisor_q      <= src2_i;
                    dividend_neg_q <= ctrl_i.signed_op & src1_i[XLEN-1];
                    divisor_neg_q  <= ctrl_i.signed_op & src2_i[XLEN-1];
                    quo_neg_q      <= ctrl_i.signed_op & (src1_i[XLEN-1] ^ src2_i[XLEN-1]);
                    rem_neg_q      <= ctrl_i.signed_op & src1_i[XLEN-1];
                    is_rem_q       <= ctrl_i.rem;
                end
            end
            DIV_CHECK: begin
                if (divisor_zero) begin
                    quo_q     <= '1;          // Remainder keeps the dividend
                    quo_neg_q <= 1'b0;
                    rem_neg_q <= 1'b0;
                end else begin
                    rem_q     <= '0;
                    quo_q     <= dividend_mag;
                    divisor_q <= divisor_mag;
                end
            end
            DIV_EXEC: begin
                if (q_bit) begin
                    rem_q <= diff[XLEN-1:0];
                end else begin
                    rem_q <= shifted[XLEN-1:0];
                end
                quo_q <= {quo_q[XLEN-2:0], q_bit};
            end
            default: ;
        endcase
    end

    assign done_o = (state_q == DIV_RET);

    always_comb begin
        if (state_q != DIV_RET) begin
            resp_o.rslt = '0;
        end else if (is_rem_q) begin
            resp_o.rslt = rem_neg_q ? -rem_q : rem_q;
        end else begin
            resp_o.rslt = quo_neg_q ? -quo_q : quo_q;
        end
    end

    a_bounded_latency : assert property (@(posedge clk_i) disable iff (rst_i)
        (start_i && state_q == DIV_IDLE) |=> ##[0:33] (state_q == DIV_RET));

endmodule

/* src/mdu_top.sv */
// ----------------------------------------------------------------------
// MDU top level
// RV32M multiply/divide unit. Joins the dispatcher to the
// multiplier and the divider
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module mdu_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  mdu_pkg::md_req_t  req_i,
    output logic              busy_o,
    output logic              done_o,
    output mdu_pkg::md_resp_t resp_o
);
    import mdu_pkg::*;

    logic      mul_start;
    mul_ctrl_t mul_ctrl;
    logic      div_start;
    div_ctrl_t div_ctrl;
    md_word_t  src1;                          // Operands shared by both units
    md_word_t  src2;
    logic      mul_done;
    md_resp_t  mul_resp;
    logic      div_done;
    md_resp_t  div_resp;

    mdu_dispatch u_dispatch (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .req_i       (req_i),
        .mul_start_o (mul_start),
        .mul_ctrl_o  (mul_ctrl),
        .div_start_o (div_start),
        .div_ctrl_o  (div_ctrl),
        .src1_o      (src1),
        .src2_o      (src2),
        .mul_done_i  (mul_done),
        .mul_resp_i  (mul_resp),
        .div_done_i  (div_done),
        .div_resp_i  (div_resp),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .resp_o      (resp_o)
    );

    mdu_multiplier u_multiplier (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (mul_start),
        .ctrl_i  (mul_ctrl),
        .src1_i  (src1),
        .src2_i  (src2),
        .done_o  (mul_done),
        .resp_o  (mul_resp)
    );

    mdu_divider u_divider (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (div_start),
        .ctrl_i  (div_ctrl),
        .src1_i  (src1),
        .src2_i  (src2),
        .done_o  (div_done),
        .resp_o  (div_resp)
    );

endmodule

/* dv/mdu_tb_checks.svh */
// ----------------------------------------------------------------------
// MDU testbench checks
// Typed compare tasks for responses, latencies and status flags,
// with one error counter for each kind of result
// ----------------------------------------------------------------------

int resp_errs    = 0;
int latency_errs = 0;
int flag_errs    = 0;

task automatic check_resp(input md_resp_t got, input md_resp_t exp, input string what);
    if (got !== exp) begin
        resp_errs++;
        $display("ERR %0t: %s gave %h, expected %h", $time, what, got.rslt, exp.rslt);
    end
endtask

task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp) begin
        latency_errs++;
        $display("ERR %0t: %s latency %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_flag(input bit got, input bit exp, input string what);
    if (got != exp) begin
        flag_errs++;
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

function automatic int error_total();
    return resp_errs + latency_errs + flag_errs;
endfunction

task automatic report_counts();
    $display("Error counts: response %0d, latency %0d, flag %0d, total %0d",
             resp_errs, latency_errs, flag_errs, error_total());
endtask

/* dv/mdu_tb.sv */
// ----------------------------------------------------------------------
// MDU testbench
// Directed and random RV32M requests against a 64-bit reference
// model, with result, latency and busy/done protocol checks
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module mdu_tb;
    import mdu_pkg::*;

    `include "mdu_tb_checks.svh"

    localparam int NUM_REQS    = 264;                // Directed 64, random 200
    localparam int CYCLE_LIMIT = NUM_REQS * 40 + 100;

    logic     clk_i;
    logic     rst_i;
    logic     start_i;
    md_req_t  req_i;
    logic     busy_o;
    logic     done_o;
    md_resp_t resp_o;
    int       cycle_cnt = 0;

    mdu_top UUT (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (start_i),
        .req_i   (req_i),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .resp_o  (resp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;                    // 8 ns period
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("Timeout: done_o was not seen within %0d cycles", CYCLE_LIMIT);
        $display("Finished with errors");
        $finish;
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic md_word_t ref_result(input md_req_t req);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     wide;
        sa = $signed(req.src1);                       // Sign extended
        sb = $signed(req.src2);
        ua = req.src1;                                // Zero extended
        ub = req.src2;
        case (req.op)
            MUL:    wide = ua * ub;
            MULH:   wide = sa * sb;
            MULHSU: wide = sa * ub;
            MULHU:  wide = ua * ub;
            DIV: begin
                if (sb == 0) begin
                    wide = '1;
                end else begin
                    wide = sa / sb;                   // Truncates toward zero
                end
            end
            DIVU:   wide = (ub == 0) ? '1 : ua / ub;
            REM: begin
                if (sb == 0) begin
                    wide = ua;
                end else begin
                    wide = sa % sb;                   // Sign of dividend
                end
            end
            default: wide = (ub == 0) ? ua : ua % ub;
        endcase
        if (req.op == DIV && req.src1 == 32'h8000_0000 && req.src2 == '1) begin
            wide = 64'h8000_0000;                     // Signed overflow
        end
        if (req.op == MULH || req.op == MULHSU || req.op == MULHU) begin
            return wide[63:32];
        end
        return wide[XLEN-1:0];
    endfunction

    function automatic int ref_latency(input md_req_t req);
        if (!req.op[2] || req.src2 == '0) begin
            return 2;                                 // Multiply or divide by zero
        end
        return 34;
    endfunction

    function automatic md_req_t make_req(input md_op_e op, input md_word_t a, input md_word_t b);
        md_req_t req;
        req.op   = op;
        req.src1 = a;
        req.src2 = b;
        return req;
    endfunction

    // ------------------------------------------------------------------
    // Request driver
    // ------------------------------------------------------------------
    task automatic issue_and_check(input md_req_t req);
        md_resp_t exp_resp;
        int       lat;
        string    what;
        exp_resp.rslt = ref_result(req);
        what = $sformatf("op %0d src1 %h src2 %h", req.op, req.src1, req.src2);
        @(posedge clk_i);
        start_i <= 1'b1;
        req_i   <= req;
        @(negedge clk_i);
        check_flag(busy_o, 1'b0, "busy_o before start");  // Also ends last done
        check_flag(done_o, 1'b0, "done_o before start");
        @(posedge clk_i);                                 // Start sampled here
        start_i <= 1'b0;
        lat = 0;
        @(negedge clk_i);
        while (!done_o) begin
            check_flag(busy_o, 1'b1, "busy_o while running");
            lat++;
            @(negedge clk_i);
        end
        check_flag(busy_o, 1'b1, "busy_o in done cycle");
        check_resp(resp_o, exp_resp, what);
        check_latency(lat, ref_latency(req), what);
    endtask

    task automatic run_mul_group(input md_word_t a, input md_word_t b);
        issue_and_check(make_req(MUL, a, b));
        issue_and_check(make_req(MULH, a, b));
        issue_and_check(make_req(MULHSU, a, b));
        issue_and_check(make_req(MULHU, a, b));
    endtask

    task automatic run_div_group(input md_word_t a, input md_word_t b);
        issue_and_check(make_req(DIV, a, b));
        issue_and_check(make_req(DIVU, a, b));
        issue_and_check(make_req(REM, a, b));
        issue_and_check(make_req(REMU, a, b));
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic check_idle_after_reset();
        md_resp_t zero_resp;
        zero_resp.rslt = '0;
        @(negedge clk_i);
        check_flag(busy_o, 1'b0, "busy_o after reset");
        check_flag(done_o, 1'b0, "done_o after reset");
        check_resp(resp_o, zero_resp, "resp_o after reset");
    endtask

    task automatic multiply_cases();
        run_mul_group(32'd7, 32'd6);
        run_mul_group(32'hffff_fffd, 32'd5);              // -3 * 5
        run_mul_group(32'd5, 32'hffff_fff9);
        run_mul_group(32'h8000_0000, 32'h8000_0000);
        run_mul_group(32'hffff_ffff, 32'hffff_ffff);
        run_mul_group(32'h8000_0000, 32'hffff_ffff);
    endtask

    task automatic divide_cases();
        run_div_group(32'd100, 32'd7);
        run_div_group(32'hffff_ff9c, 32'd7);              // -100 / 7
        run_div_group(32'd100, 32'hffff_fff9);
        run_div_group(32'hffff_ff9c, 32'hffff_fff9);
        run_div_group(32'hffff_ffff, 32'd3);
        run_div_group(32'd7, 32'd100);
    endtask

    task automatic divide_corner_cases();
        run_div_group(32'd1234, 32'd0);
        run_div_group(32'h8000_0000, 32'd0);
        run_div_group(32'h8000_0000, 32'hffff_ffff);      // Signed overflow
    endtask

    task automatic back_to_back_sequence();
        issue_and_check(make_req(MUL, 32'h1234_5678, 32'h9abc_def0));
        issue_and_check(make_req(DIV, 32'hdead_beef, 32'd17));
        issue_and_check(make_req(MULHU, 32'hcafe_f00d, 32'h0bad_c0de));
        issue_and_check(make_req(REMU, 32'hdead_beef, 32'd0));
    endtask

    task automatic random_requests(input int count);
        md_req_t req;
        for (int i = 0; i < count; i++) begin
            req.op   = md_op_e'($urandom_range(7, 0));
            req.src1 = $urandom();
            req.src2 = ($urandom_range(15, 0) == 0) ? '0 : $urandom();  // Some zero divisors
            issue_and_check(req);
        end
    endtask

    initial begin
        void'($urandom(32'h6bc5762c));
        rst_i   = 1'b1;
        start_i = 1'b0;
        req_i   = '0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        check_idle_after_reset();
        multiply_cases();
        divide_cases();
        divide_corner_cases();
        back_to_back_sequence();
        random_requests(200);
        @(negedge clk_i);
        check_flag(busy_o, 1'b0, "busy_o after last request");
        check_flag(done_o, 1'b0, "done_o after last request");
        report_counts();
        if (error_total() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+dv
src/mdu_pkg.sv
src/mdu_dispatch.sv
src/mdu_multiplier.sv
src/mdu_divider.sv
src/mdu_top.sv
dv/mdu_tb.sv
